// ==== common/cmdIf.sv ====
`default_nettype none
`timescale 1ns/1ps

interface cmdIf;
	logic commandReady;
	termPkg::CommandsType commandType;
	logic [7:0] pn;
	logic [7:0] ch;

	modport source
	(
		output commandReady, commandType, pn, ch
	);

	modport sink
	(
		input commandReady, commandType, pn, ch
	);
endinterface

`default_nettype wire

// ==== common/colorPkg.sv ====
`default_nettype none

package colorPkg;

	// red in the top bits
	typedef logic [8:0] color9_t;

	typedef struct packed
	{
		logic underline;
		logic blink;
		logic negative;
		logic bright;
	} effect_t;

	typedef struct packed
	{
		color9_t fg;
		color9_t bg;
		effect_t effect;
	} Graphics_t;

	// sel bit 0 is red, bit 2 is blue
	function automatic color9_t basicColor(input logic [2:0] sel, input logic [2:0] level);
		return {sel[0] ? level : 3'd0, sel[1] ? level : 3'd0, sel[2] ? level : 3'd0};
	endfunction

endpackage

`default_nettype wire

// ==== common/termPkg.sv ====
`default_nettype none

package termPkg;

	// command bus opcodes
	typedef enum logic [2:0]
	{
		NONE,
		PRINT,
		INIT_PN,
		EMIT_PN,
		SGR,
		SGR0
	} CommandsType;

	// byte level parser
	typedef enum logic [1:0]
	{
		GROUND,
		ESCAPE,
		CSI
	} ParserStateType;

	// extended colour tracking across SGR parameters
	typedef enum logic [3:0]
	{
		SGR_START,
		SGR_FG,
		SGR_FG_IDX,
		SGR_FG_R,
		SGR_FG_G,
		SGR_FG_B,
		SGR_BG,
		SGR_BG_IDX,
		SGR_BG_R,
		SGR_BG_G,
		SGR_BG_B
	} SgrStateType;

endpackage

`default_nettype wire

// ==== common/term_consts.svh ====
`ifndef TERM_CONSTS_SVH
`define TERM_CONSTS_SVH

// power-up colours, light grey on black
`define DEFAULT_FG 9'b110_110_110
`define DEFAULT_BG 9'b000_000_000

// sequence bytes
`define ESC_BYTE 8'h1B
`define CSI_BYTE 8'h5B
`define SGR_FINAL 8'h6D

// parameter accumulation stops here
`define PN_MAX 8'd255

`endif

// ==== graphics/Color256Decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module Color256Decoder
(
	input wire [7:0] code,
	output colorPkg::color9_t color
);
	logic [7:0] cubeIdx;
	logic [2:0] red;
	logic [2:0] green;
	logic [2:0] blue;
	logic [2:0] greyLevel;

	// six cube steps squeezed onto eight levels
	function automatic logic [2:0] cubeLevel(input logic [2:0] step);
		case (step)
			3'd0: return 3'd0;
			3'd1: return 3'd2;
			3'd2: return 3'd3;
			3'd3: return 3'd4;
			3'd4: return 3'd6;
			default: return 3'd7;
		endcase
	endfunction

	assign cubeIdx = code - 8'd16;
	assign red = 3'(cubeIdx / 8'd36);
	assign green = 3'((cubeIdx / 8'd6) % 8'd6);
	assign blue = 3'(cubeIdx % 8'd6);
	assign greyLevel = 3'((code - 8'd232) / 8'd3);

	always_comb
	begin
		if (code < 8'd8)
			color = colorPkg::basicColor(code[2:0], 3'd5);
		else if (code < 8'd16)
			color = colorPkg::basicColor(code[2:0], 3'd7);
		else if (code < 8'd232)
			color = {cubeLevel(red), cubeLevel(green), cubeLevel(blue)};
		else
			color = {3{greyLevel}};
	end

endmodule

`default_nettype wire

// ==== graphics/GraphicsControl.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "term_consts.svh"

module GraphicsControl
(
	input wire clk,
	input wire rst,
	cmdIf.sink cmd,
	output colorPkg::Graphics_t graphics
);
	localparam colorPkg::Graphics_t defaultGraphics =
		'{fg: `DEFAULT_FG, bg: `DEFAULT_BG, effect: 4'b0000};
	localparam colorPkg::color9_t lightGrey = 9'b110_110_110;

	termPkg::SgrStateType status;
	colorPkg::Graphics_t workGraphics;
	colorPkg::color9_t paletteColor;
	logic graphicsReady;
	logic [7:0] offs30;
	logic [7:0] offs40;
	logic [7:0] offs90;
	logic [7:0] offs100;

	assign offs30 = cmd.pn - 8'd30;
	assign offs40 = cmd.pn - 8'd40;
	assign offs90 = cmd.pn - 8'd90;
	assign offs100 = cmd.pn - 8'd100;

	Color256Decoder Color256Decoder_i
	(
		.code(cmd.pn),
		.color(paletteColor)
	);

	// 38/48 then 5;n or 2;r;g;b
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			status <= termPkg::SGR_START;
		else if (cmd.commandReady)
		begin
			if (cmd.commandType == termPkg::EMIT_PN)
			begin
				case (status)
					termPkg::SGR_START:
						if (cmd.pn == 8'd38)
							status <= termPkg::SGR_FG;
						else if (cmd.pn == 8'd48)
							status <= termPkg::SGR_BG;
					termPkg::SGR_FG:
						if (cmd.pn == 8'd5)
							status <= termPkg::SGR_FG_IDX;
						else if (cmd.pn == 8'd2)
							status <= termPkg::SGR_FG_R;
						else
							status <= termPkg::SGR_START;
					termPkg::SGR_FG_R:
						status <= termPkg::SGR_FG_G;
					termPkg::SGR_FG_G:
						status <= termPkg::SGR_FG_B;
					termPkg::SGR_BG:
						if (cmd.pn == 8'd5)
							status <= termPkg::SGR_BG_IDX;
						else if (cmd.pn == 8'd2)
							status <= termPkg::SGR_BG_R;
						else
							status <= termPkg::SGR_START;
					termPkg::SGR_BG_R:
						status <= termPkg::SGR_BG_G;
					termPkg::SGR_BG_G:
						status <= termPkg::SGR_BG_B;
					default:
						status <= termPkg::SGR_START;
				endcase
			end
			else
				// new sequence or its last parameter
				status <= termPkg::SGR_START;
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			graphicsReady <= 1'b0;
		else
			graphicsReady <= cmd.commandReady &&
				(cmd.commandType == termPkg::SGR || cmd.commandType == termPkg::SGR0);
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			graphics <= defaultGraphics;
		else if (graphicsReady)
			graphics <= workGraphics;
	end

	// working copy, edited once per parameter
	always_ff @(posedge clk)
	begin
		if (cmd.commandReady)
		begin
			case (cmd.commandType)
				termPkg::INIT_PN:
					workGraphics <= graphics;
				termPkg::SGR0:
					workGraphics <= defaultGraphics;
				termPkg::EMIT_PN, termPkg::SGR:
					case (status)
						termPkg::SGR_START:
							case (cmd.pn) inside
								8'd0: workGraphics <= defaultGraphics;
								8'd1: workGraphics.effect.bright <= 1'b1;
								8'd4: workGraphics.effect.underline <= 1'b1;
								8'd5: workGraphics.effect.blink <= 1'b1;
								8'd7: workGraphics.effect.negative <= 1'b1;
								8'd22: workGraphics.effect.bright <= 1'b0;
								8'd24: workGraphics.effect.underline <= 1'b0;
								8'd25: workGraphics.effect.blink <= 1'b0;
								8'd27: workGraphics.effect.negative <= 1'b0;
								[8'd30:8'd36]:
									workGraphics.fg <= colorPkg::basicColor(offs30[2:0], 3'd5);
								8'd37: workGraphics.fg <= lightGrey;
								[8'd40:8'd46]:
									workGraphics.bg <= colorPkg::basicColor(offs40[2:0], 3'd5);
								8'd47: workGraphics.bg <= lightGrey;
								// bright variants
								[8'd90:8'd97]:
									workGraphics.fg <= colorPkg::basicColor(offs90[2:0], 3'd7);
								[8'd100:8'd107]:
									workGraphics.bg <= colorPkg::basicColor(offs100[2:0], 3'd7);
								default: ;
							endcase
						termPkg::SGR_FG_IDX: workGraphics.fg <= paletteColor;
						termPkg::SGR_BG_IDX: workGraphics.bg <= paletteColor;
						// direct rgb keeps the top bits
						termPkg::SGR_FG_R: workGraphics.fg[8:6] <= cmd.pn[7:5];
						termPkg::SGR_FG_G: workGraphics.fg[5:3] <= cmd.pn[7:5];
						termPkg::SGR_FG_B: workGraphics.fg[2:0] <= cmd.pn[7:5];
						termPkg::SGR_BG_R: workGraphics.bg[8:6] <= cmd.pn[7:5];
						termPkg::SGR_BG_G: workGraphics.bg[5:3] <= cmd.pn[7:5];
						termPkg::SGR_BG_B: workGraphics.bg[2:0] <= cmd.pn[7:5];
						default: ;
					endcase
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		graphicsReady |=> !graphicsReady);

endmodule

`default_nettype wire

// ==== logic/CellEmitter.sv ====
`default_nettype none
`timescale 1ns/1ps

module CellEmitter
(
	input wire clk,
	input wire rst,
	input wire colorPkg::Graphics_t graphics,
	input wire cellAck,
	cmdIf.sink cmd,
	output logic cellBusy,
	output logic cellReq,
	output logic [7:0] cellChar,
	output colorPkg::color9_t cellFg,
	output colorPkg::color9_t cellBg,
	output colorPkg::effect_t cellEffect
);
	logic latchCell;

	assign latchCell = cmd.commandReady && (cmd.commandType == termPkg::PRINT) && !cellBusy;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			cellBusy <= 1'b0;
			cellReq <= 1'b0;
		end
		else if (latchCell)
		begin
			cellBusy <= 1'b1;
			cellReq <= 1'b1;
		end
		else if (cellReq)
		begin
			// receiver has the cell
			if (cellAck)
				cellReq <= 1'b0;
		end
		else if (cellBusy && !cellAck)
			cellBusy <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (latchCell)
		begin
			cellChar <= cmd.ch;
			cellFg <= graphics.fg;
			cellBg <= graphics.bg;
			cellEffect <= graphics.effect;
		end
	end

	// parser holds printables back while busy
	assert property (@(posedge clk) disable iff (rst)
		(cmd.commandReady && cmd.commandType == termPkg::PRINT) |-> !cellBusy);

endmodule

`default_nettype wire

// ==== logic/TermCore.sv ====
`default_nettype none
`timescale 1ns/1ps

module TermCore
(
	input wire clk,
	input wire rst,
	input wire byteReq,
	input wire [7:0] byteData,
	input wire cellAck,
	output logic byteAck,
	output logic cellReq,
	output logic [7:0] cellChar,
	output colorPkg::color9_t cellFg,
	output colorPkg::color9_t cellBg,
	output colorPkg::effect_t cellEffect
);
	logic cellBusy;
	colorPkg::Graphics_t graphics;

	cmdIf cmdBus();

	EscapeParser EscapeParser_i
	(
		.clk(clk),
		.rst(rst),
		.byteReq(byteReq),
		.byteData(byteData),
		.cellBusy(cellBusy),
		.byteAck(byteAck),
		.cmd(cmdBus.source)
	);

	GraphicsControl GraphicsControl_i
	(
		.clk(clk),
		.rst(rst),
		.cmd(cmdBus.sink),
		.graphics(graphics)
	);

	CellEmitter CellEmitter_i
	(
		.clk(clk),
		.rst(rst),
		.graphics(graphics),
		.cellAck(cellAck),
		.cmd(cmdBus.sink),
		.cellBusy(cellBusy),
		.cellReq(cellReq),
		.cellChar(cellChar),
		.cellFg(cellFg),
		.cellBg(cellBg),
		.cellEffect(cellEffect)
	);

endmodule

`default_nettype wire

// ==== parser/EscapeParser.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "term_consts.svh"

module EscapeParser
(
	input wire clk,
	input wire rst,
	input wire byteReq,
	input wire [7:0] byteData,
	input wire cellBusy,
	output logic byteAck,
	cmdIf.source cmd
);
	termPkg::ParserStateType state;
	termPkg::ParserStateType stateNext;
	termPkg::CommandsType cmdNext;
	logic [7:0] pnAcc;
	logic [7:0] pnSat;
	logic [11:0] pnNext;
	logic pnSeen;
	logic isPrintable;
	logic isDigit;
	logic isSemi;
	logic takeByte;

	assign isPrintable = (byteData >= 8'h20) && (byteData <= 8'h7E);
	assign isDigit = (byteData >= 8'h30) && (byteData <= 8'h39);
	assign isSemi = (byteData == 8'h3B);

	// a printable in ground state waits until the emitter is free
	assign takeByte = byteReq && !byteAck &&
		!(state == termPkg::GROUND && isPrintable && cellBusy);

	assign pnNext = {4'd0, pnAcc} * 12'd10 + {8'd0, byteData[3:0]};
	assign pnSat = (pnNext > {4'd0, `PN_MAX}) ? `PN_MAX : pnNext[7:0];

	always_comb
	begin
		cmdNext = termPkg::NONE;
		stateNext = state;
		case (state)
			termPkg::GROUND:
				if (byteData == `ESC_BYTE)
					stateNext = termPkg::ESCAPE;
				else if (isPrintable)
					cmdNext = termPkg::PRINT;
			termPkg::ESCAPE:
				if (byteData == `CSI_BYTE)
				begin
					stateNext = termPkg::CSI;
					cmdNext = termPkg::INIT_PN;
				end
				else
					stateNext = termPkg::GROUND;
			termPkg::CSI:
				if (isSemi)
					cmdNext = termPkg::EMIT_PN;
				else if (byteData == `SGR_FINAL)
				begin
					stateNext = termPkg::GROUND;
					cmdNext = pnSeen ? termPkg::SGR : termPkg::SGR0;
				end
				else if (!isDigit)
					// abort, nothing is sent
					stateNext = termPkg::GROUND;
			default:
				stateNext = termPkg::GROUND;
		endcase
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			byteAck <= 1'b0;
		else if (takeByte)
			byteAck <= 1'b1;
		else if (!byteReq)
			byteAck <= 1'b0;
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= termPkg::GROUND;
			pnAcc <= 8'd0;
			pnSeen <= 1'b0;
			cmd.commandReady <= 1'b0;
		end
		else
		begin
			cmd.commandReady <= takeByte && (cmdNext != termPkg::NONE);
			if (takeByte)
			begin
				state <= stateNext;
				if (cmdNext == termPkg::INIT_PN || cmdNext == termPkg::EMIT_PN)
					pnAcc <= 8'd0;
				else if (state == termPkg::CSI && isDigit)
					pnAcc <= pnSat;
				if (cmdNext == termPkg::INIT_PN)
					pnSeen <= 1'b0;
				else if (state == termPkg::CSI && (isDigit || isSemi))
					pnSeen <= 1'b1;
			end
		end
	end

	// pn is the parameter closed by this byte
	always_ff @(posedge clk)
	begin
		if (takeByte)
		begin
			cmd.commandType <= cmdNext;
			cmd.pn <= pnAcc;
			cmd.ch <= byteData;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		cmd.commandReady |=> !cmd.commandReady);

	assert property (@(posedge clk) disable iff (rst)
		$rose(byteAck) |-> $past(byteReq));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the termSgr testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=TermCore_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f termSgr.f -o "$TOP"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== termSgr.f ====
+incdir+common
common/termPkg.sv
common/colorPkg.sv
common/cmdIf.sv
graphics/Color256Decoder.sv
parser/EscapeParser.sv
graphics/GraphicsControl.sv
logic/CellEmitter.sv
logic/TermCore.sv
verif/TermCore_tb.sv

// ==== verif/TermCore_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module TermCore_tb;

	localparam int TABLE_ROWS = 27;
	localparam int RANDOM_ROWS = 8;

	logic clk;
	logic rst;
	logic byteReq;
	logic [7:0] byteData;
	logic cellAck;
	logic byteAck;
	logic cellReq;
	logic [7:0] cellChar;
	colorPkg::color9_t cellFg;
	colorPkg::color9_t cellBg;
	colorPkg::effect_t cellEffect;

	// expected cell is {char, fg, bg, effect}
	// colours in octal r-g-b
	// effect bits are underline, blink, negative, bright
	string tableText [TABLE_ROWS] = '{
		"A",
		"\033[1mB",
		"\033[4mC",
		"\033[5;7mD",
		"\033[22;24mE",
		"\033[25;27mF",
		"\033[1;4mG",
		"\033[0mH",
		"\033[7mI",
		"\033[mJ",
		"\033[31;42mK",
		"\033[34;45mL",
		"\033[37;47mM",
		"\033[33;40mN",
		"\033[91;104mO",
		"\033[97;100mP",
		"\033[36;46mQ",
		"\033[0;38;2;255;128;64mR",
		"\033[48;2;31;32;224mS",
		"\033[38;1;48;7mT",
		"\001\t\177V",
		"\033[31xW",
		"\033QX",
		"\033[2560;1mY",
		"\033[0mZ",
		"\033[38;5;9;48;5;244mz",
		"\033[4;38;5;75;48;5;3m!"
	};
	logic [29:0] tableExp [TABLE_ROWS] = '{
		{"A", 9'o666, 9'o000, 4'b0000},
		{"B", 9'o666, 9'o000, 4'b0001},
		{"C", 9'o666, 9'o000, 4'b1001},
		{"D", 9'o666, 9'o000, 4'b1111},
		{"E", 9'o666, 9'o000, 4'b0110},
		{"F", 9'o666, 9'o000, 4'b0000},
		{"G", 9'o666, 9'o000, 4'b1001},
		{"H", 9'o666, 9'o000, 4'b0000},
		{"I", 9'o666, 9'o000, 4'b0010},
		{"J", 9'o666, 9'o000, 4'b0000},
		{"K", 9'o500, 9'o050, 4'b0000},
		{"L", 9'o005, 9'o505, 4'b0000},
		{"M", 9'o666, 9'o666, 4'b0000},
		{"N", 9'o550, 9'o000, 4'b0000},
		{"O", 9'o700, 9'o007, 4'b0000},
		{"P", 9'o777, 9'o000, 4'b0000},
		{"Q", 9'o055, 9'o055, 4'b0000},
		{"R", 9'o742, 9'o000, 4'b0000},
		{"S", 9'o742, 9'o017, 4'b0000},
		{"T", 9'o742, 9'o017, 4'b0000},
		{"V", 9'o742, 9'o017, 4'b0000},
		{"W", 9'o742, 9'o017, 4'b0000},
		{"X", 9'o742, 9'o017, 4'b0000},
		{"Y", 9'o742, 9'o017, 4'b0001},
		{"Z", 9'o666, 9'o000, 4'b0000},
		{"z", 9'o700, 9'o444, 4'b0000},
		{"!", 9'o247, 9'o550, 4'b1000}
	};

	string stimText[$];
	logic [29:0] stimExp[$];
	logic [29:0] expQ[$];
	logic [31:0] rngState;
	int cycleLimit;
	int mismatchCount;
	int missingCount;
	int unexpectedCount;

	TermCore TermCore_i
	(
		.clk(clk),
		.rst(rst),
		.byteReq(byteReq),
		.byteData(byteData),
		.cellAck(cellAck),
		.byteAck(byteAck),
		.cellReq(cellReq),
		.cellChar(cellChar),
		.cellFg(cellFg),
		.cellBg(cellBg),
		.cellEffect(cellEffect)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int unsigned nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return int'(rngState >> 16);
	endfunction

	// xterm palette from the colour rules
	function automatic logic [8:0] paletteModel(input int n);
		int levels [6];
		int level;
		int r;
		int g;
		int b;
		levels = '{0, 2, 3, 4, 6, 7};
		if (n < 16)
		begin
			level = (n < 8) ? 5 : 7;
			r = (n % 2) * level;
			g = ((n / 2) % 2) * level;
			b = ((n / 4) % 2) * level;
		end
		else if (n < 232)
		begin
			r = levels[(n - 16) / 36];
			g = levels[((n - 16) / 6) % 6];
			b = levels[(n - 16) % 6];
		end
		else
		begin
			r = (n - 232) / 3;
			g = r;
			b = r;
		end
		return {r[2:0], g[2:0], b[2:0]};
	endfunction

	task automatic sendByte(input logic [7:0] b);
		byteData = b;
		byteReq = 1'b1;
		@(negedge clk);
		while (!byteAck)
			@(negedge clk);
		byteReq = 1'b0;
		@(negedge clk);
		while (byteAck)
			@(negedge clk);
	endtask

	task automatic checkCell();
		logic [29:0] exp;
		logic [29:0] got;
		got = {cellChar, cellFg, cellBg, cellEffect};
		assert (expQ.size() != 0)
		else
		begin
			unexpectedCount++;
			$display("unexpected cell '%c' arrived while no cell was pending", cellChar);
		end
		if (expQ.size() != 0)
		begin
			exp = expQ.pop_front();
			assert (got == exp)
			else
			begin
				mismatchCount++;
				$display("mismatch at %0t: expected '%c' fg %o bg %o effect %b",
					$time, exp[29:22], exp[21:13], exp[12:4], exp[3:0]);
				$display("mismatch at %0t: got '%c' fg %o bg %o effect %b",
					$time, got[29:22], got[21:13], got[12:4], got[3:0]);
			end
		end
	endtask

	task automatic reportCounts();
		$display("errors: %0d mismatch, %0d missing, %0d unexpected",
			mismatchCount, missingCount, unexpectedCount);
	endtask

	// receiver with a random ack delay
	initial
	begin
		int delay;
		forever
		begin
			@(negedge clk);
			if (!rst && cellReq && !cellAck)
			begin
				delay = nextRandom() % 6;
				repeat (delay) @(negedge clk);
				checkCell();
				cellAck = 1'b1;
				@(negedge clk);
				while (cellReq)
					@(negedge clk);
				cellAck = 1'b0;
			end
		end
	end

	initial
	begin
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		reportCounts();
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int fgIdx;
		int bgIdx;
		int row;
		int j;
		int totalBytes;
		int waitCycles;
		string text;
		rst = 1'b1;
		byteReq = 1'b0;
		byteData = 8'h00;
		cellAck = 1'b0;
		rngState = 32'ha019;
		mismatchCount = 0;
		missingCount = 0;
		unexpectedCount = 0;

		for (row = 0; row < TABLE_ROWS; row++)
		begin
			stimText.push_back(tableText[row]);
			stimExp.push_back(tableExp[row]);
		end
		// random palette picks with model expectations
		for (row = 0; row < RANDOM_ROWS; row++)
		begin
			fgIdx = nextRandom() % 256;
			bgIdx = nextRandom() % 256;
			text = $sformatf("\033[0;38;5;%0d;48;5;%0dm%c", fgIdx, bgIdx, 8'h61 + row);
			stimText.push_back(text);
			stimExp.push_back({8'(8'h61 + row), paletteModel(fgIdx), paletteModel(bgIdx), 4'b0000});
		end
		totalBytes = 0;
		foreach (stimText[row])
			totalBytes += stimText[row].len();
		cycleLimit = 40 * totalBytes + 400;

		repeat (5) @(negedge clk);
		rst = 1'b0;

		for (row = 0; row < stimText.size(); row++)
		begin
			expQ.push_back(stimExp[row]);
			text = stimText[row];
			for (j = 0; j < text.len(); j++)
				sendByte(text[j]);
		end

		waitCycles = 0;
		while ((expQ.size() != 0 || cellReq || cellAck) && waitCycles < 200)
		begin
			@(negedge clk);
			waitCycles++;
		end
		assert (expQ.size() == 0)
		else
		begin
			missingCount = expQ.size();
			$display("%0d expected cells never came out of the DUT", expQ.size());
		end

		reportCounts();
		if (mismatchCount + missingCount + unexpectedCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
